//--- design/rv_config.svh
// data width, register count, CSR addresses and exception cause codes
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and PC width
`define XLEN 32

// architectural GPRs, 16 gives RV32E
`define GPR_COUNT 32

// width of a CSR address field
`define CSR_ADDR_W 12

// machine-mode CSR addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC 12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

// mcause values for synchronous exceptions
`define CAUSE_ILLEGAL 8'd2
`define CAUSE_BREAKPOINT 8'd3
`define CAUSE_ECALL_M 8'd11

`endif

//--- design/rv_pkg.sv
// enumerated decode types for ALU op, immediate format, write-back, jump and CSR op
package rv_pkg;

	// ALU operation for the execute stage
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	// immediate format selected by the decoder
	typedef enum logic [2:0] {
		IMM_NONE = 3'd0,
		IMM_I    = 3'd1,
		IMM_S    = 3'd2,
		IMM_B    = 3'd3,
		IMM_U    = 3'd4,
		IMM_J    = 3'd5
	} imm_type_t;

	// source of the value written to rd
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2,
		WB_CSR = 2'd3
	} wb_sel_t;

	// control transfer kind, branches carry their compare
	typedef enum logic [3:0] {
		JMP_NONE = 4'd0,
		JMP_JAL  = 4'd1,
		JMP_JALR = 4'd2,
		JMP_BEQ  = 4'd3,
		JMP_BNE  = 4'd4,
		JMP_BLT  = 4'd5,
		JMP_BGE  = 4'd6,
		JMP_BLTU = 4'd7,
		JMP_BGEU = 4'd8,
		JMP_MRET = 4'd9
	} jump_t;

	typedef enum logic [1:0] {
		CSR_OP_NONE = 2'd0,
		CSR_OP_RW   = 2'd1,
		CSR_OP_RS   = 2'd2,
		CSR_OP_RC   = 2'd3
	} csr_op_t;

endpackage

//--- design/gpr_file.sv
// general-purpose register file, two write-first read ports and x0 fixed at zero
`timescale 1ns/1ps
`include "rv_config.svh"

module gpr_file (
	input  logic              clk,
	input  logic              reset,
	input  logic              we,
	input  logic [4:0]        waddr,
	input  logic [4:0]        raddr1,
	input  logic [4:0]        raddr2,
	input  logic [`XLEN-1:0]  wdata,
	output logic [`XLEN-1:0]  rdata1,
	output logic [`XLEN-1:0]  rdata2
);

	localparam int IDX_W = $clog2(`GPR_COUNT);

	logic [`XLEN-1:0] regs [`GPR_COUNT];
	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx1;
	logic [IDX_W-1:0] ridx2;

	// upper index bits dropped when GPR_COUNT is 16
	assign widx  = waddr[IDX_W-1:0];
	assign ridx1 = raddr1[IDX_W-1:0];
	assign ridx2 = raddr2[IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `GPR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && widx != '0) begin
			regs[widx] <= wdata;
		end
	end

	// bypass a same-cycle write so the reader sees the new value
	assign rdata1 = (ridx1 == '0) ? '0 : (we && widx == ridx1) ? wdata : regs[ridx1];
	assign rdata2 = (ridx2 == '0) ? '0 : (we && widx == ridx2) ? wdata : regs[ridx2];

	a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

//--- design/csr_file.sv
// machine CSRs with software write port, trap entry and mtvec/mepc outputs
`timescale 1ns/1ps
`include "rv_config.svh"

module csr_file (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`CSR_ADDR_W-1:0] raddr,
	output logic [`XLEN-1:0]       rdata,
	input  logic                   we,
	input  logic [`CSR_ADDR_W-1:0] waddr,
	input  logic [`XLEN-1:0]       wdata,
	input  logic                   trap_valid,
	input  logic [`XLEN-1:0]       trap_cause,
	input  logic [`XLEN-1:0]       trap_pc,
	output logic [`XLEN-1:0]       mtvec,
	output logic [`XLEN-1:0]       mepc
);

	logic [`XLEN-1:0] mstatus_q;
	logic [`XLEN-1:0] mtvec_q;
	logic [`XLEN-1:0] mepc_q;
	logic [`XLEN-1:0] mcause_q;
	logic [`XLEN-1:0] mscratch_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			mstatus_q  <= '0;
			mtvec_q    <= '0;
			mepc_q     <= '0;
			mcause_q   <= '0;
			mscratch_q <= '0;
		end else begin
			if (we) begin
				case (waddr)
					`CSR_MSTATUS:  mstatus_q  <= wdata;
					// mode bits kept as written
					`CSR_MTVEC:    mtvec_q    <= wdata;
					`CSR_MEPC:     mepc_q     <= wdata;
					`CSR_MCAUSE:   mcause_q   <= wdata;
					`CSR_MSCRATCH: mscratch_q <= wdata;
					default: ;
				endcase
			end
			// trap entry comes last so it overrides a software write
			if (trap_valid) begin
				mepc_q   <= trap_pc;
				mcause_q <= trap_cause;
			end
		end
	end

	// unimplemented addresses read as zero
	always_comb begin
		case (raddr)
			`CSR_MSTATUS:  rdata = mstatus_q;
			`CSR_MTVEC:    rdata = mtvec_q;
			`CSR_MEPC:     rdata = mepc_q;
			`CSR_MCAUSE:   rdata = mcause_q;
			`CSR_MSCRATCH: rdata = mscratch_q;
			default:       rdata = '0;
		endcase
	end

	// redirect targets for fetch
	assign mtvec = mtvec_q;
	assign mepc  = mepc_q;

	a_trap_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(trap_valid));

endmodule

//--- design/imm_gen.sv
// immediate extraction and sign extension for I, S, B, U and J formats
`timescale 1ns/1ps
`include "rv_config.svh"

module imm_gen
	import rv_pkg::*;
(
	input  logic [31:0]       instr,
	input  imm_type_t         imm_type,
	output logic [`XLEN-1:0]  imm
);

	logic sign;

	// every format takes its sign from bit 31
	assign sign = instr[31];

	always_comb begin
		case (imm_type)
			IMM_I: begin
				imm = {{(`XLEN-12){sign}}, instr[31:20]};
			end
			IMM_S: begin
				imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
			end
			IMM_B: begin
				imm = {{(`XLEN-13){sign}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			// upper 20 bits, low 12 cleared
			IMM_U: begin
				imm = {{(`XLEN-32){sign}}, instr[31:12], 12'b0};
			end
			IMM_J: begin
				imm = {{(`XLEN-21){sign}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

//--- design/decode_ctrl.sv
// RV32I opcode decoder producing execute control fields and decode exceptions
`timescale 1ns/1ps
`include "rv_config.svh"

module decode_ctrl
	import rv_pkg::*;
(
	input  logic [31:0] instr,
	output alu_op_t     alu_op,
	output logic        alu_src_a_pc,
	output logic        alu_src_b_imm,
	output logic        gpr_we,
	output logic        mem_read,
	output logic        mem_write,
	output logic [2:0]  mem_size,
	output wb_sel_t     wb_sel,
	output jump_t       jump,
	output csr_op_t     csr_op,
	output imm_type_t   imm_type,
	output logic        exc_valid,
	output logic [7:0]  exc_cause
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// fixed SYSTEM encodings
	localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       illegal;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	// load/store width passed through as funct3
	assign mem_size = funct3;

	// alt selects sub and sra
	function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		alu_op        = ALU_ADD;
		alu_src_a_pc  = 1'b0;
		alu_src_b_imm = 1'b0;
		gpr_we        = 1'b0;
		mem_read      = 1'b0;
		mem_write     = 1'b0;
		wb_sel        = WB_ALU;
		jump          = JMP_NONE;
		csr_op        = CSR_OP_NONE;
		imm_type      = IMM_NONE;
		exc_valid     = 1'b0;
		exc_cause     = '0;
		illegal       = 1'b0;

		case (opcode)
			OPC_LUI: begin
				gpr_we        = 1'b1;
				imm_type      = IMM_U;
				alu_src_b_imm = 1'b1;
				alu_op        = ALU_PASS_B;
			end
			OPC_AUIPC: begin
				gpr_we        = 1'b1;
				imm_type      = IMM_U;
				alu_src_a_pc  = 1'b1;
				alu_src_b_imm = 1'b1;
			end
			// ALU forms the target, rd gets pc+4
			OPC_JAL: begin
				gpr_we        = 1'b1;
				imm_type      = IMM_J;
				alu_src_a_pc  = 1'b1;
				alu_src_b_imm = 1'b1;
				wb_sel        = WB_PC4;
				jump          = JMP_JAL;
			end
			OPC_JALR: begin
				gpr_we        = 1'b1;
				imm_type      = IMM_I;
				alu_src_b_imm = 1'b1;
				wb_sel        = WB_PC4;
				jump          = JMP_JALR;
				illegal       = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				imm_type = IMM_B;
				alu_op   = ALU_SUB;
				case (funct3)
					3'b000:  jump = JMP_BEQ;
					3'b001:  jump = JMP_BNE;
					3'b100:  jump = JMP_BLT;
					3'b101:  jump = JMP_BGE;
					3'b110:  jump = JMP_BLTU;
					3'b111:  jump = JMP_BGEU;
					default: illegal = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				gpr_we        = 1'b1;
				mem_read      = 1'b1;
				imm_type      = IMM_I;
				alu_src_b_imm = 1'b1;
				wb_sel        = WB_MEM;
				// lb lh lw lbu lhu only
				illegal = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
			end
			OPC_STORE: begin
				mem_write     = 1'b1;
				imm_type      = IMM_S;
				alu_src_b_imm = 1'b1;
				illegal       = (funct3 > 3'b010);
			end
			OPC_OPIMM: begin
				gpr_we        = 1'b1;
				imm_type      = IMM_I;
				alu_src_b_imm = 1'b1;
				alu_op        = alu_of(funct3, (funct3 == 3'b101) && funct7[5]);
				if (funct3 == 3'b001) begin
					illegal = (funct7 != 7'b0000000);
				end else if (funct3 == 3'b101) begin
					illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
				end
			end
			OPC_OP: begin
				gpr_we  = 1'b1;
				alu_op  = alu_of(funct3, funct7[5]);
				illegal = !((funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			OPC_SYSTEM: begin
				case (funct3)
					3'b000: begin
						if (instr == INSTR_ECALL) begin
							exc_valid = 1'b1;
							exc_cause = `CAUSE_ECALL_M;
						end else if (instr == INSTR_EBREAK) begin
							exc_valid = 1'b1;
							exc_cause = `CAUSE_BREAKPOINT;
						end else if (instr == INSTR_MRET) begin
							jump = JMP_MRET;
						end else begin
							illegal = 1'b1;
						end
					end
					3'b001: csr_op = CSR_OP_RW;
					3'b010: csr_op = CSR_OP_RS;
					3'b011: csr_op = CSR_OP_RC;
					default: illegal = 1'b1;
				endcase
				if (funct3 != 3'b000) begin
					gpr_we = !illegal;
					wb_sel = WB_CSR;
				end
			end
			default: begin
				illegal = 1'b1;
			end
		endcase

		// illegal encodings must not change any state
		if (illegal) begin
			gpr_we    = 1'b0;
			mem_read  = 1'b0;
			mem_write = 1'b0;
			jump      = JMP_NONE;
			csr_op    = CSR_OP_NONE;
			exc_valid = 1'b1;
			exc_cause = `CAUSE_ILLEGAL;
		end
	end

endmodule

//--- design/decode_stage.sv
// decode stage top with valid/ready handshakes, stage register and decode blocks
`timescale 1ns/1ps
`include "rv_config.svh"

module decode_stage
	import rv_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  logic [31:0]            in_instr,
	input  logic [`XLEN-1:0]       in_pc,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic [`XLEN-1:0]       out_pc,
	output logic [`XLEN-1:0]       out_imm,
	output logic [`XLEN-1:0]       out_rs1_data,
	output logic [`XLEN-1:0]       out_rs2_data,
	output logic [`XLEN-1:0]       out_csr_rdata,
	output logic [4:0]             out_rd,
	output alu_op_t                out_alu_op,
	output logic                   out_alu_src_a_pc,
	output logic                   out_alu_src_b_imm,
	output logic                   out_gpr_we,
	output logic                   out_mem_read,
	output logic                   out_mem_write,
	output logic [2:0]             out_mem_size,
	output wb_sel_t                out_wb_sel,
	output jump_t                  out_jump,
	output csr_op_t                out_csr_op,
	output imm_type_t              out_imm_type,
	output logic                   out_exc_valid,
	output logic [7:0]             out_exc_cause,
	input  logic                   wb_gpr_we,
	input  logic [4:0]             wb_gpr_addr,
	input  logic [`XLEN-1:0]       wb_gpr_data,
	input  logic                   wb_csr_we,
	input  logic [`CSR_ADDR_W-1:0] wb_csr_addr,
	input  logic [`XLEN-1:0]       wb_csr_data,
	input  logic                   trap_valid,
	input  logic [`XLEN-1:0]       trap_cause,
	input  logic [`XLEN-1:0]       trap_pc,
	output logic [`XLEN-1:0]       mtvec,
	output logic [`XLEN-1:0]       mepc
);

	logic                  valid_q;
	logic [31:0]           instr_q;
	logic [`XLEN-1:0]      pc_q;
	logic [`XLEN-1:0]      rs1_q;
	logic [`XLEN-1:0]      rs2_q;
	logic [`XLEN-1:0]      rs1_rd;
	logic [`XLEN-1:0]      rs2_rd;
	logic                  accept;

	// accept when empty or when the held item drains this cycle
	assign in_ready = !valid_q || out_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
		end else if (out_ready) begin
			valid_q <= 1'b0;
		end
	end

	// operands sampled on the accept edge
	always_ff @(posedge clk) begin
		if (accept) begin
			instr_q <= in_instr;
			pc_q    <= in_pc;
			rs1_q   <= rs1_rd;
			rs2_q   <= rs2_rd;
		end
	end

	assign out_valid    = valid_q;
	assign out_pc       = pc_q;
	assign out_rs1_data = rs1_q;
	assign out_rs2_data = rs2_q;
	assign out_rd       = instr_q[11:7];

	gpr_file u_gpr_file (
		.clk    (clk),
		.reset  (reset),
		.we     (wb_gpr_we),
		.waddr  (wb_gpr_addr),
		.raddr1 (in_instr[19:15]),
		.raddr2 (in_instr[24:20]),
		.wdata  (wb_gpr_data),
		.rdata1 (rs1_rd),
		.rdata2 (rs2_rd)
	);

	// CSR read follows the held instruction
	csr_file u_csr_file (
		.clk        (clk),
		.reset      (reset),
		.raddr      (instr_q[31:20]),
		.rdata      (out_csr_rdata),
		.we         (wb_csr_we),
		.waddr      (wb_csr_addr),
		.wdata      (wb_csr_data),
		.trap_valid (trap_valid),
		.trap_cause (trap_cause),
		.trap_pc    (trap_pc),
		.mtvec      (mtvec),
		.mepc       (mepc)
	);

	decode_ctrl u_decode_ctrl (
		.instr         (instr_q),
		.alu_op        (out_alu_op),
		.alu_src_a_pc  (out_alu_src_a_pc),
		.alu_src_b_imm (out_alu_src_b_imm),
		.gpr_we        (out_gpr_we),
		.mem_read      (out_mem_read),
		.mem_write     (out_mem_write),
		.mem_size      (out_mem_size),
		.wb_sel        (out_wb_sel),
		.jump          (out_jump),
		.csr_op        (out_csr_op),
		.imm_type      (out_imm_type),
		.exc_valid     (out_exc_valid),
		.exc_cause     (out_exc_cause)
	);

	imm_gen u_imm_gen (
		.instr    (instr_q),
		.imm_type (out_imm_type),
		.imm      (out_imm)
	);

	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_pc));

endmodule

//--- verif/tb_decode_stage.sv
// testbench for decode_stage with reference model, concurrent checks and timeout
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_decode_stage
	import rv_pkg::*;
();

	localparam int NUM_ITEMS      = 500;
	localparam int TIMEOUT_CYCLES = 6000;

	logic clk = 1'b0;
	logic reset;
	logic in_valid, in_ready, out_valid, out_ready;
	logic [31:0] in_instr;
	logic [`XLEN-1:0] in_pc, out_pc, out_imm, out_rs1_data, out_rs2_data, out_csr_rdata;
	logic [4:0] out_rd;
	alu_op_t out_alu_op;
	logic out_alu_src_a_pc, out_alu_src_b_imm, out_gpr_we, out_mem_read, out_mem_write;
	logic [2:0] out_mem_size;
	wb_sel_t out_wb_sel;
	jump_t out_jump;
	csr_op_t out_csr_op;
	imm_type_t out_imm_type;
	logic out_exc_valid;
	logic [7:0] out_exc_cause;
	logic wb_gpr_we, wb_csr_we, trap_valid;
	logic [4:0] wb_gpr_addr;
	logic [`CSR_ADDR_W-1:0] wb_csr_addr;
	logic [`XLEN-1:0] wb_gpr_data, wb_csr_data, trap_cause, trap_pc, mtvec, mepc;

	integer seed = 32'h5bfabc7e;
	int cycles = 0;

	// reference state
	logic [31:0] q_instr [$];
	logic [31:0] q_pc [$];
	logic [31:0] q_rs1 [$];
	logic [31:0] q_rs2 [$];
	logic [31:0] shadow_gpr [`GPR_COUNT];
	logic [31:0] sh_mstatus, sh_mtvec, sh_mepc, sh_mcause, sh_mscratch;

	// expected view of the held item refreshed after every edge
	logic head_valid = 1'b0;
	logic reset_q = 1'b1;
	logic [31:0] head_instr, head_pc, head_imm, head_rs1, head_rs2, head_csr;
	logic [20:0] head_ctrl;
	logic [10:0] head_exec;
	logic [31:0] exp_mtvec, exp_mepc;
	logic [20:0] dut_ctrl;
	logic [10:0] dut_exec;
	logic xfer;

	assign xfer = out_valid && out_ready;
	assign dut_ctrl = {out_gpr_we, out_mem_read, out_mem_write, out_wb_sel, out_jump,
		out_imm_type, out_exc_valid, out_exc_cause};
	assign dut_exec = {out_alu_op, out_alu_src_a_pc, out_alu_src_b_imm, out_mem_size,
		out_csr_op};

	always #5 clk = ~clk;

	decode_stage u_decode_stage (
		.clk (clk), .reset (reset),
		.in_valid (in_valid), .in_ready (in_ready), .in_instr (in_instr), .in_pc (in_pc),
		.out_valid (out_valid), .out_ready (out_ready), .out_pc (out_pc),
		.out_imm (out_imm), .out_rs1_data (out_rs1_data), .out_rs2_data (out_rs2_data),
		.out_csr_rdata (out_csr_rdata), .out_rd (out_rd), .out_alu_op (out_alu_op),
		.out_alu_src_a_pc (out_alu_src_a_pc), .out_alu_src_b_imm (out_alu_src_b_imm),
		.out_gpr_we (out_gpr_we), .out_mem_read (out_mem_read),
		.out_mem_write (out_mem_write), .out_mem_size (out_mem_size),
		.out_wb_sel (out_wb_sel), .out_jump (out_jump), .out_csr_op (out_csr_op),
		.out_imm_type (out_imm_type), .out_exc_valid (out_exc_valid),
		.out_exc_cause (out_exc_cause),
		.wb_gpr_we (wb_gpr_we), .wb_gpr_addr (wb_gpr_addr), .wb_gpr_data (wb_gpr_data),
		.wb_csr_we (wb_csr_we), .wb_csr_addr (wb_csr_addr), .wb_csr_data (wb_csr_data),
		.trap_valid (trap_valid), .trap_cause (trap_cause), .trap_pc (trap_pc),
		.mtvec (mtvec), .mepc (mepc)
	);

	task automatic report_failure(input string msg);
		$display("Fail %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic logic [11:0] csr_pick(input logic [2:0] sel);
		case (sel)
			3'd0: return `CSR_MSTATUS;
			3'd1, 3'd7: return `CSR_MTVEC;
			3'd2: return `CSR_MEPC;
			3'd3, 3'd6: return `CSR_MCAUSE;
			3'd4: return `CSR_MSCRATCH;
			default: return 12'h7c0;
		endcase
	endfunction

	// immediate format by opcode class
	function automatic imm_type_t ref_fmt(input logic [31:0] ins);
		case (ins[6:0])
			7'h37, 7'h17: return IMM_U;
			7'h6f: return IMM_J;
			7'h67, 7'h03, 7'h13: return IMM_I;
			7'h63: return IMM_B;
			7'h23: return IMM_S;
			default: return IMM_NONE;
		endcase
	endfunction

	// built from the arithmetic-shifted top twelve bits
	function automatic logic [31:0] ref_imm(input logic [31:0] ins);
		logic [31:0] hi;
		hi = $signed(ins) >>> 20;
		case (ref_fmt(ins))
			IMM_I: return hi;
			IMM_S: return (hi & 32'hffff_ffe0) | {27'b0, ins[11:7]};
			IMM_B: return (hi & 32'hffff_f7e0) | {20'b0, ins[7], 11'b0}
				| {27'b0, ins[11:8], 1'b0};
			IMM_U: return ins & 32'hffff_f000;
			IMM_J: return (hi & 32'hfff0_07fe) | (ins & 32'h000f_f000)
				| {20'b0, ins[20], 11'b0};
			default: return 32'h0;
		endcase
	endfunction

	// {gpr_we, mem_read, mem_write, wb_sel, jump, imm_type, exc_valid, exc_cause}
	function automatic logic [20:0] ref_ctrl(input logic [31:0] ins);
		logic we, mr, mw, exc;
		wb_sel_t wb;
		jump_t jmp;
		logic [7:0] cause;
		we = 1'b0;
		mr = 1'b0;
		mw = 1'b0;
		exc = 1'b0;
		wb = WB_ALU;
		jmp = JMP_NONE;
		cause = 8'd0;
		case (ins[6:0])
			7'h37, 7'h17, 7'h13, 7'h33: we = 1'b1;
			7'h6f: begin
				we = 1'b1;
				wb = WB_PC4;
				jmp = JMP_JAL;
			end
			7'h67: begin
				we = 1'b1;
				wb = WB_PC4;
				jmp = JMP_JALR;
			end
			7'h63: begin
				case (ins[14:12])
					3'd0: jmp = JMP_BEQ;
					3'd1: jmp = JMP_BNE;
					3'd4: jmp = JMP_BLT;
					3'd5: jmp = JMP_BGE;
					3'd6: jmp = JMP_BLTU;
					default: jmp = JMP_BGEU;
				endcase
			end
			7'h03: begin
				we = 1'b1;
				mr = 1'b1;
				wb = WB_MEM;
			end
			7'h23: mw = 1'b1;
			7'h73: begin
				if (ins[14:12] != 3'b000) begin
					we = 1'b1;
					wb = WB_CSR;
				end else if (ins == 32'h0000_0073) begin
					exc = 1'b1;
					cause = `CAUSE_ECALL_M;
				end else if (ins == 32'h0010_0073) begin
					exc = 1'b1;
					cause = `CAUSE_BREAKPOINT;
				end else begin
					jmp = JMP_MRET;
				end
			end
			default: begin
				exc = 1'b1;
				cause = `CAUSE_ILLEGAL;
			end
		endcase
		return {we, mr, mw, wb, jmp, ref_fmt(ins), exc, cause};
	endfunction

	// {alu_op, alu_src_a_pc, alu_src_b_imm, mem_size, csr_op}
	function automatic logic [10:0] exec_ref(input logic [31:0] ins);
		alu_op_t op;
		logic a_pc;
		logic b_imm;
		csr_op_t cop;
		op = ALU_ADD;
		a_pc = 1'b0;
		b_imm = 1'b0;
		cop = CSR_OP_NONE;
		case (ins[6:0])
			7'h37: begin
				op = ALU_PASS_B;
				b_imm = 1'b1;
			end
			7'h17, 7'h6f: begin
				a_pc = 1'b1;
				b_imm = 1'b1;
			end
			7'h67, 7'h03, 7'h23: b_imm = 1'b1;
			7'h63: op = ALU_SUB;
			// bit 5 of the opcode tells OP from OP-IMM, only OP has sub
			7'h13, 7'h33: begin
				b_imm = !ins[5];
				case (ins[14:12])
					3'd0: op = (ins[5] && ins[30]) ? ALU_SUB : ALU_ADD;
					3'd1: op = ALU_SLL;
					3'd2: op = ALU_SLT;
					3'd3: op = ALU_SLTU;
					3'd4: op = ALU_XOR;
					3'd5: op = ins[30] ? ALU_SRA : ALU_SRL;
					3'd6: op = ALU_OR;
					default: op = ALU_AND;
				endcase
			end
			7'h73: begin
				case (ins[14:12])
					3'd1: cop = CSR_OP_RW;
					3'd2: cop = CSR_OP_RS;
					3'd3: cop = CSR_OP_RC;
					default: cop = CSR_OP_NONE;
				endcase
			end
			default: ;
		endcase
		return {op, a_pc, b_imm, ins[14:12], cop};
	endfunction

	function automatic logic [31:0] csr_ref(input logic [11:0] addr);
		case (addr)
			`CSR_MSTATUS: return sh_mstatus;
			`CSR_MTVEC: return sh_mtvec;
			`CSR_MEPC: return sh_mepc;
			`CSR_MCAUSE: return sh_mcause;
			`CSR_MSCRATCH: return sh_mscratch;
			default: return 32'h0;
		endcase
	endfunction

	// operand seen at the accept edge where a write on that edge wins
	function automatic logic [31:0] gpr_ref(input logic [4:0] addr);
		int idx;
		idx = addr % `GPR_COUNT;
		if (idx == 0)
			return 32'h0;
		if (wb_gpr_we && (wb_gpr_addr % `GPR_COUNT) == idx)
			return wb_gpr_data;
		return shadow_gpr[idx];
	endfunction

	// one random legal instruction per class or an unknown opcode
	task automatic build_instr(output logic [31:0] ins);
		logic [31:0] r;
		logic [2:0] f3;
		int kind;
		r = $random(seed);
		kind = $unsigned($random(seed)) % 12;
		f3 = r[14:12];
		ins = r;
		case (kind)
			0: ins[6:0] = 7'h37;
			1: ins[6:0] = 7'h17;
			2: ins[6:0] = 7'h6f;
			3: begin
				ins[6:0] = 7'h67;
				ins[14:12] = 3'b000;
			end
			4: begin
				ins[6:0] = 7'h63;
				if (!f3[2])
					ins[13] = 1'b0;
			end
			5: begin
				ins[6:0] = 7'h03;
				if (f3[2])
					ins[13] = 1'b0;
				else if (f3[1:0] == 2'b11)
					ins[12] = 1'b0;
			end
			6: begin
				ins[6:0] = 7'h23;
				ins[14] = 1'b0;
				if (f3[1:0] == 2'b11)
					ins[12] = 1'b0;
			end
			7: begin
				ins[6:0] = 7'h13;
				if (f3 == 3'd1)
					ins[31:25] = 7'b0;
				else if (f3 == 3'd5)
					ins[31:25] = {1'b0, r[30], 5'b0};
			end
			8: begin
				ins[6:0] = 7'h33;
				ins[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'b0} : 7'b0;
			end
			9: begin
				ins[6:0] = 7'h73;
				ins[14:12] = {1'b0, (f3[1:0] == 2'b00) ? 2'b10 : f3[1:0]};
				ins[31:20] = csr_pick(r[9:7] ^ r[17:15]);
			end
			10: begin
				case (r[1:0])
					2'd1: ins = 32'h0010_0073;
					2'd2: ins = 32'h3020_0073;
					default: ins = 32'h0000_0073;
				endcase
			end
			default: begin
				case (r[6:0])
					7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33, 7'h73:
						ins[6:0] = 7'h7f;
					default: ;
				endcase
			end
		endcase
	endtask

	task automatic send_item(input logic [31:0] ins, input logic [31:0] pc);
		logic taken;
		in_valid <= 1'b1;
		in_instr <= ins;
		in_pc    <= pc;
		// in_ready has settled by the falling edge
		do begin
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
		end while (!taken);
		in_valid <= 1'b0;
	endtask

	// back-pressure, write-back and trap traffic
	always @(posedge clk) begin : side_traffic
		logic [31:0] r;
		r = $random(seed);
		if (reset) begin
			out_ready  <= 1'b0;
			wb_gpr_we  <= 1'b0;
			wb_csr_we  <= 1'b0;
			trap_valid <= 1'b0;
		end else begin
			out_ready   <= r[1:0] != 2'b00;
			wb_gpr_we   <= r[2];
			// often aim at the waiting rs1
			wb_gpr_addr <= r[3] ? in_instr[19:15] : r[8:4];
			wb_gpr_data <= $random(seed);
			wb_csr_we   <= r[11:9] == 3'b000;
			wb_csr_addr <= csr_pick(r[14:12]);
			wb_csr_data <= $random(seed);
			trap_valid  <= r[18:15] == 4'b0000;
			trap_cause  <= {24'b0, r[26:19]};
			trap_pc     <= $random(seed) & 32'hffff_fffc;
		end
	end

	always @(posedge clk) begin : ref_model
		int wi;
		if (reset) begin
			q_instr.delete();
			q_pc.delete();
			q_rs1.delete();
			q_rs2.delete();
			for (int i = 0; i < `GPR_COUNT; i++)
				shadow_gpr[i] = 32'h0;
			{sh_mstatus, sh_mtvec, sh_mepc, sh_mcause, sh_mscratch} = '0;
		end else begin
			if (xfer && q_pc.size() != 0) begin
				void'(q_instr.pop_front());
				void'(q_pc.pop_front());
				void'(q_rs1.pop_front());
				void'(q_rs2.pop_front());
			end
			if (in_valid && in_ready) begin
				q_instr.push_back(in_instr);
				q_pc.push_back(in_pc);
				q_rs1.push_back(gpr_ref(in_instr[19:15]));
				q_rs2.push_back(gpr_ref(in_instr[24:20]));
			end
			wi = wb_gpr_addr % `GPR_COUNT;
			if (wb_gpr_we && wi != 0)
				shadow_gpr[wi] = wb_gpr_data;
			if (wb_csr_we) begin
				case (wb_csr_addr)
					`CSR_MSTATUS: sh_mstatus = wb_csr_data;
					`CSR_MTVEC: sh_mtvec = wb_csr_data;
					`CSR_MEPC: sh_mepc = wb_csr_data;
					`CSR_MCAUSE: sh_mcause = wb_csr_data;
					`CSR_MSCRATCH: sh_mscratch = wb_csr_data;
					default: ;
				endcase
			end
			// trap entry overrides a software write
			if (trap_valid) begin
				sh_mepc = trap_pc;
				sh_mcause = trap_cause;
			end
		end
		head_valid <= q_pc.size() != 0;
		if (q_pc.size() != 0) begin
			head_instr <= q_instr[0];
			head_pc    <= q_pc[0];
			head_rs1   <= q_rs1[0];
			head_rs2   <= q_rs2[0];
			head_imm   <= ref_imm(q_instr[0]);
			head_ctrl  <= ref_ctrl(q_instr[0]);
			head_exec  <= exec_ref(q_instr[0]);
			head_csr   <= csr_ref(q_instr[0][31:20]);
		end
		exp_mtvec <= sh_mtvec;
		exp_mepc  <= sh_mepc;
		reset_q   <= reset;
	end

	a_after_reset: assert property (@(posedge clk) reset_q && !reset |-> !out_valid && in_ready)
		else report_failure("out_valid or in_ready wrong right after reset");
	a_order: assert property (@(posedge clk) disable iff (reset)
		xfer |-> head_valid && out_pc == head_pc && out_rd == head_instr[11:7])
		else report_failure($sformatf("item out of order, pc %h expected %h", out_pc, head_pc));
	a_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_imm)
			&& $stable(out_rs1_data) && $stable(out_rs2_data))
		else report_failure("held item changed under back-pressure");
	a_operands: assert property (@(posedge clk) disable iff (reset)
		xfer |-> out_rs1_data == head_rs1 && out_rs2_data == head_rs2)
		else report_failure($sformatf("operands %h %h, expected %h %h",
			out_rs1_data, out_rs2_data, head_rs1, head_rs2));
	a_x0: assert property (@(posedge clk) disable iff (reset)
		xfer |-> (head_instr[19:15] != 5'd0 || out_rs1_data == '0)
			&& (head_instr[24:20] != 5'd0 || out_rs2_data == '0))
		else report_failure("x0 read back non-zero");
	a_imm: assert property (@(posedge clk) disable iff (reset) xfer |-> out_imm == head_imm)
		else report_failure($sformatf("imm %h, expected %h for instr %h",
			out_imm, head_imm, head_instr));
	a_ctrl: assert property (@(posedge clk) disable iff (reset) xfer |-> dut_ctrl == head_ctrl)
		else report_failure($sformatf("control %h, expected %h for instr %h",
			dut_ctrl, head_ctrl, head_instr));
	a_exec: assert property (@(posedge clk) disable iff (reset) xfer |-> dut_exec == head_exec)
		else report_failure($sformatf("execute fields %h, expected %h for instr %h",
			dut_exec, head_exec, head_instr));
	a_csr_rdata: assert property (@(posedge clk) disable iff (reset)
		xfer |-> out_csr_rdata == head_csr)
		else report_failure($sformatf("csr read %h, expected %h", out_csr_rdata, head_csr));
	a_redirect: assert property (@(posedge clk) disable iff (reset)
		mtvec == exp_mtvec && mepc == exp_mepc)
		else report_failure($sformatf("mtvec %h mepc %h, expected %h %h",
			mtvec, mepc, exp_mtvec, exp_mepc));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	initial begin
		logic [31:0] ins;
		logic [31:0] pc;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = 32'h0;
		in_pc = 32'h0;
		out_ready = 1'b0;
		wb_gpr_we = 1'b0;
		wb_gpr_addr = 5'd0;
		wb_gpr_data = 32'h0;
		wb_csr_we = 1'b0;
		wb_csr_addr = '0;
		wb_csr_data = 32'h0;
		trap_valid = 1'b0;
		trap_cause = 32'h0;
		trap_pc = 32'h0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		pc = 32'h0000_1000;
		for (int n = 0; n < NUM_ITEMS; n++) begin
			build_instr(ins);
			send_item(ins, pc);
			pc = pc + 32'd4;
			// occasional idle cycle on the fetch side
			if (($random(seed) & 7) == 0)
				@(posedge clk);
		end
		do
			@(negedge clk);
		while (q_pc.size() != 0 || out_valid);
		repeat (2) @(posedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+design
design/rv_pkg.sv
design/gpr_file.sv
design/csr_file.sv
design/imm_gen.sv
design/decode_ctrl.sv
design/decode_stage.sv
verif/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_decode_stage
out=$(./obj_dir/Vtb_decode_stage 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
